// ==== compile.f ====
design/lcd_pkg.sv
design/dash_pkg.sv
design/change_scanner.sv
design/field_mask.sv
design/lcd_sequencer.sv
design/lcd_bit_clock.sv
design/byte_serializer.sv
design/dash_lcd_top.sv
tb/dash_lcd_assert.sv
tb/tb_dash_lcd.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dash_lcd
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert -Wall
RUN_ARGS  ?= +verilator+error+limit+100
SOURCES   := $(wildcard design/*.sv tb/*.sv)
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_ARGS) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/tb_dash_lcd.sv ====
`timescale 1ns/1ps

module tb_dash_lcd;
    import dash_pkg::*;

    localparam int QUIET_CYCLES = 150;
    localparam int TAIL_CYCLES  = 300;
    localparam int BYTE_CYCLES  = 600;

    logic                        CLK_I = 1'b0;
    logic                        RST_I;
    logic [NUM_FLAGS-1:0]        flags;         // kmh in bit 0, colon in bit 6
    logic [NUM_DIGITS-1:0][7:0]  digits;        // lower1 in slot 0
    logic                        CS1_N_O;
    logic                        SI_O;
    logic                        A0_O;
    logic                        SCL_O;

    logic [NUM_FLAGS-1:0]        model_flags;
    logic [NUM_DIGITS-1:0][7:0]  model_digits;
    logic [8:0]                  exp_q [$];     // {a0, byte}
    int                          byte_count = 0;
    int                          cycle_count = 0;
    int                          cycle_limit = 200 + QUIET_CYCLES + TAIL_CYCLES;
    logic                        decode_en = 1'b0;
    logic [7:0]                  rx_byte = '0;
    int                          rx_bits = 0;

    always #50 CLK_I = ~CLK_I;

    dash_lcd_top #(.SCL_DIV(4), .CREDITS(2)) i_dash_lcd_top (
        .CLK_I(CLK_I), .RST_I(RST_I),
        .kmh(flags[0]), .avs(flags[1]), .day(flags[2]), .max(flags[3]),
        .tim(flags[4]), .point(flags[5]), .colon(flags[6]),
        .lower1(digits[0]), .lower10(digits[1]), .lower100(digits[2]),
        .lower1000(digits[3]), .upper1(digits[4]), .upper10(digits[5]),
        .CS1_N_O(CS1_N_O), .SI_O(SI_O), .A0_O(A0_O), .SCL_O(SCL_O)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    // Expected frame of one field, straight from the position and text tables
    task automatic queue_field(input int f, input logic [7:0] value);
        logic [3:0]  page;
        logic [7:0]  col;
        logic [23:0] text;
        int          len;
        page = field_page[f];
        col  = field_column[f];
        len  = int'(field_length[f]);
        if (f < NUM_FLAGS) text = value[0] ? flag_text[f] : 24'h0;
        else text = {value, 16'h0};
        exp_q.push_back({1'b0, 4'hB, page});
        exp_q.push_back({1'b0, 4'h1, col[7:4]});
        exp_q.push_back({1'b0, 4'h0, col[3:0]});
        for (int i = 0; i < len; i++) begin
            exp_q.push_back({1'b1, text[23 - 8 * i -: 8]});
        end
        cycle_limit += BYTE_CYCLES * (3 + len);
    endtask

    task automatic apply_inputs(input logic [NUM_FLAGS-1:0] new_flags,
                                input logic [NUM_DIGITS-1:0][7:0] new_digits);
        @(posedge CLK_I);
        flags  <= new_flags;
        digits <= new_digits;
        for (int f = 0; f < NUM_FLAGS; f++) begin
            if (new_flags[f] != model_flags[f]) queue_field(f, {7'h0, new_flags[f]});
        end
        for (int d = 0; d < NUM_DIGITS; d++) begin
            if (new_digits[d] != model_digits[d]) queue_field(d + NUM_FLAGS, new_digits[d]);
        end
        model_flags  = new_flags;
        model_digits = new_digits;
        while (exp_q.size() != 0) @(posedge CLK_I);
        while (!CS1_N_O) @(posedge CLK_I);
    endtask

    task automatic check_byte(input logic [8:0] got);
        logic [8:0] expected;
        if (exp_q.size() == 0) begin
            abort_run($sformatf("Byte 9'h%03h arrived with no frame pending", got));
        end else begin
            expected = exp_q.pop_front();
            byte_count++;
            assert (got == expected) else begin
                $display("[ERROR] A0_O/SI_O entry %0d: expected 9'h%03h, actual 9'h%03h",
                         byte_count, expected, got);
                abort_run("Serial byte did not match the expected frame");
            end
        end
    endtask

    // Serial decoder, MSB first
    always @(posedge SCL_O) begin
        if (decode_en && !CS1_N_O) begin
            rx_byte = {rx_byte[6:0], SI_O};
            rx_bits++;
            if (rx_bits == 8) begin
                rx_bits = 0;
                check_byte({A0_O, rx_byte});
            end
        end
    end

    always @(posedge CLK_I) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            abort_run($sformatf("Timeout after %0d cycles, %0d bytes still missing",
                                cycle_count, exp_q.size()));
        end
    end

    always @(negedge CLK_I) begin
        if (i_dash_lcd_top.i_dash_lcd_assert.failed) begin
            abort_run("A bound protocol assertion failed");
        end
    end

    initial begin
        logic [NUM_FLAGS-1:0]       f;
        logic [NUM_DIGITS-1:0][7:0] d;
        int                         idx;
        void'($urandom(32'h5881_0a66));
        RST_I        = 1'b1;
        flags        = '0;
        digits       = '0;
        model_flags  = '0;
        model_digits = '0;
        f            = '0;
        d            = '0;
        repeat (2) @(posedge CLK_I);
        RST_I     <= 1'b0;
        decode_en <= 1'b1;
        repeat (QUIET_CYCLES) @(posedge CLK_I);  // Bus must stay quiet here
        f[0] = 1'b1;
        apply_inputs(f, d);
        f[0] = 1'b0;
        apply_inputs(f, d);
        repeat (8) begin
            idx    = int'($urandom_range(NUM_DIGITS - 1));
            d[idx] = d[idx] ^ (8'($urandom) | 8'h01); // Always a new code
            apply_inputs(f, d);
        end
        f    = '1;  // All flags and two digits in one cycle
        d[1] = d[1] ^ (8'($urandom) | 8'h01);
        d[4] = d[4] ^ (8'($urandom) | 8'h01);
        apply_inputs(f, d);
        repeat (4) begin
            f = 7'($urandom);
            d = 48'({$urandom, $urandom});
            apply_inputs(f, d);
        end
        f = '0;
        apply_inputs(f, d);
        repeat (TAIL_CYCLES) @(posedge CLK_I);   // Catches any extra frame
        if (exp_q.size() != 0 || i_dash_lcd_top.i_dash_lcd_assert.failed) begin
            abort_run("Run ended with bytes missing or a failed assertion");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// ==== tb/dash_lcd_assert.sv ====
`timescale 1ns/1ps

module dash_lcd_assert (
    input logic        CLK_I,
    input logic        RST_I,
    input logic        cs_n,
    input logic        scl,
    input logic        a0,
    input logic        field_valid,
    input logic [6:0]  flags,
    input logic [47:0] digits
);

    logic       scl_q;
    logic [3:0] rise_count;          // SCL rises in this CS low window
    logic       active;              // Some input left zero since reset
    logic       idle_bad = 1'b0;
    logic       scl_bad = 1'b0;
    logic       a0_bad = 1'b0;
    logic       bits_bad = 1'b0;
    logic       gap_bad = 1'b0;
    logic       failed;

    assign failed = idle_bad | scl_bad | a0_bad | bits_bad | gap_bad;

    always_ff @(posedge CLK_I) begin
        scl_q <= scl;
        if (RST_I) begin
            rise_count <= '0;
            active     <= 1'b0;
        end else begin
            if ((|flags) || (|digits)) active <= 1'b1;
            if (cs_n) rise_count <= '0;
            else if (scl && !scl_q) rise_count <= rise_count + 4'd1;
        end
    end

    idle_quiet: assert property (@(posedge CLK_I) disable iff (RST_I)
        !active |-> (cs_n && scl && !field_valid))
    else begin
        $error("Serial bus moved while all inputs stayed zero");
        idle_bad = 1'b1;
    end

    scl_parked: assert property (@(posedge CLK_I) disable iff (RST_I) cs_n |-> scl)
    else begin
        $error("SCL_O low while CS1_N_O is high");
        scl_bad = 1'b1;
    end

    a0_steady: assert property (@(posedge CLK_I) disable iff (RST_I) !cs_n |-> $stable(a0))
    else begin
        $error("A0_O changed while CS1_N_O was low");
        a0_bad = 1'b1;
    end

    eight_bits: assert property (@(posedge CLK_I) disable iff (RST_I)
        $rose(cs_n) |-> (rise_count == 4'd8))
    else begin
        $error("CS1_N_O window did not hold exactly 8 SCL_O rises");
        bits_bad = 1'b1;
    end

    cs_gap: assert property (@(posedge CLK_I) disable iff (RST_I)
        !cs_n |-> (rise_count <= 4'd8))
    else begin
        $error("CS1_N_O stayed low past one byte");
        gap_bad = 1'b1;
    end

endmodule

bind dash_lcd_top dash_lcd_assert i_dash_lcd_assert (
    .CLK_I(CLK_I),
    .RST_I(RST_I),
    .cs_n(CS1_N_O),
    .scl(SCL_O),
    .a0(A0_O),
    .field_valid(field_valid),
    .flags({colon, point, tim, max, day, avs, kmh}),
    .digits({upper10, upper1, lower1000, lower100, lower10, lower1})
);

// ==== design/dash_lcd_top.sv ====
`timescale 1ns/1ps

module dash_lcd_top #(
    parameter int SCL_DIV = 4,
    parameter int CREDITS = 2
) (
    input  logic            CLK_I,
    input  logic            RST_I,
    input  logic            kmh,
    input  logic            avs,
    input  logic            day,
    input  logic            max,
    input  logic            tim,
    input  logic            point,
    input  logic            colon,
    input  dash_pkg::char_t lower1,
    input  dash_pkg::char_t lower10,
    input  dash_pkg::char_t lower100,
    input  dash_pkg::char_t lower1000,
    input  dash_pkg::char_t upper1,
    input  dash_pkg::char_t upper10,
    output logic            CS1_N_O,
    output logic            SI_O,
    output logic            A0_O,
    output logic            SCL_O
);
    import dash_pkg::*;
    import lcd_pkg::*;

    logic       idle;
    logic       field_valid;
    field_t     field_id;
    page_t      page;
    column_t    column;
    logic [1:0] length;
    char_t      char0;
    char_t      char1;
    char_t      char2;
    logic       push;
    lcd_entry_t entry;
    logic       credit_return;
    logic       tick;

    change_scanner i_change_scanner (
        .CLK_I, .RST_I, .kmh, .avs, .day, .max, .tim, .point, .colon,
        .lower1, .lower10, .lower100, .lower1000, .upper1, .upper10,
        .idle, .field_valid, .field_id
    );

    field_mask i_field_mask (
        .CLK_I, .RST_I, .field_valid, .field_id,
        .kmh, .avs, .day, .max, .tim, .point, .colon,
        .lower1, .lower10, .lower100, .lower1000, .upper1, .upper10,
        .page, .column, .length, .char0, .char1, .char2
    );

    lcd_sequencer #(.CREDITS(CREDITS)) i_lcd_sequencer (
        .CLK_I, .RST_I, .field_valid, .page, .column, .length,
        .char0, .char1, .char2, .credit_return, .idle, .push, .entry
    );

    lcd_bit_clock #(.SCL_DIV(SCL_DIV)) i_lcd_bit_clock (
        .CLK_I, .RST_I, .tick
    );

    byte_serializer #(.CREDITS(CREDITS)) i_byte_serializer (
        .CLK_I, .RST_I, .tick, .push, .entry, .credit_return,
        .scl(SCL_O), .si(SI_O), .cs_n(CS1_N_O), .a0(A0_O)
    );

endmodule

// ==== design/byte_serializer.sv ====
`timescale 1ns/1ps

module byte_serializer #(
    parameter int CREDITS = 2
) (
    input  logic                CLK_I,
    input  logic                RST_I,
    input  logic                tick,
    input  logic                push,
    input  lcd_pkg::lcd_entry_t entry,
    output logic                credit_return,
    output logic                scl,
    output logic                si,
    output logic                cs_n,
    output logic                a0
);
    import lcd_pkg::*;

    localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int CNT_W = $clog2(CREDITS + 1);

    localparam logic [1:0] SH_IDLE  = 2'd0;
    localparam logic [1:0] SH_START = 2'd1;
    localparam logic [1:0] SH_SHIFT = 2'd2;
    localparam logic [1:0] SH_STOP  = 2'd3;

    lcd_entry_t       slot_mem [CREDITS];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic [1:0]       sh_state;
    logic [3:0]       phase;           // Half-bit count within the byte
    logic [7:0]       shreg;
    logic             pop;

    assign pop = tick && (sh_state == SH_IDLE) && (fill != '0);

    always_ff @(posedge CLK_I) begin
        if (push) slot_mem[wr_ptr] <= entry;
    end

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == PTR_W'(CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)  rd_ptr <= (rd_ptr == PTR_W'(CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            fill <= fill + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge CLK_I) begin
        if (pop) begin
            shreg <= slot_mem[rd_ptr].value;
        end else if (tick && sh_state == SH_SHIFT && !phase[0]) begin
            shreg <= {shreg[6:0], 1'b0}; // MSB first
        end
    end

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            sh_state      <= SH_IDLE;
            phase         <= '0;
            cs_n          <= 1'b1;
            scl           <= 1'b1;
            si            <= 1'b0;
            a0            <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= 1'b0;
            if (tick) begin
                case (sh_state)
                    SH_IDLE: begin
                        if (pop) begin
                            a0       <= slot_mem[rd_ptr].a0; // Settles while CS is high
                            sh_state <= SH_START;
                        end
                    end
                    SH_START: begin
                        cs_n     <= 1'b0;
                        phase    <= '0;
                        sh_state <= SH_SHIFT;
                    end
                    SH_SHIFT: begin
                        scl   <= phase[0];
                        phase <= phase + 4'd1;
                        if (!phase[0]) si <= shreg[7]; // Change on the falling edge
                        if (phase == 4'd15) sh_state <= SH_STOP;
                    end
                    default: begin
                        cs_n          <= 1'b1;
                        si            <= 1'b0;
                        credit_return <= 1'b1;
                        sh_state      <= SH_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

// ==== design/lcd_bit_clock.sv ====
`timescale 1ns/1ps

module lcd_bit_clock #(
    parameter int SCL_DIV = 4
) (
    input  logic CLK_I,
    input  logic RST_I,
    output logic tick
);

    localparam int CNT_W = (SCL_DIV > 1) ? $clog2(SCL_DIV) : 1;

    logic [CNT_W-1:0] count;

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            count <= CNT_W'(SCL_DIV - 1);
            tick  <= 1'b0;
        end else if (count == '0) begin
            count <= CNT_W'(SCL_DIV - 1); // Reload
            tick  <= 1'b1;
        end else begin
            count <= count - 1'b1;
            tick  <= 1'b0;
        end
    end

endmodule

// ==== design/lcd_sequencer.sv ====
`timescale 1ns/1ps

module lcd_sequencer #(
    parameter int CREDITS = 2
) (
    input  logic               CLK_I,
    input  logic               RST_I,
    input  logic               field_valid,
    input  lcd_pkg::page_t     page,
    input  lcd_pkg::column_t   column,
    input  logic [1:0]         length,
    input  dash_pkg::char_t    char0,
    input  dash_pkg::char_t    char1,
    input  dash_pkg::char_t    char2,
    input  logic               credit_return,
    output logic               idle,
    output logic               push,
    output lcd_pkg::lcd_entry_t entry
);
    import lcd_pkg::*;

    localparam int CNT_W = $clog2(CREDITS + 1);

    localparam logic [2:0] S_IDLE     = 3'd0;
    localparam logic [2:0] S_PAGE     = 3'd1;
    localparam logic [2:0] S_COL_HIGH = 3'd2;
    localparam logic [2:0] S_COL_LOW  = 3'd3;
    localparam logic [2:0] S_DATA     = 3'd4;

    logic [2:0]       state;
    logic [CNT_W-1:0] credits;
    logic [1:0]       data_idx;
    logic             spend;
    lcd_byte_t        next_byte;
    logic             next_a0;

    assign idle  = (state == S_IDLE);
    assign spend = !idle && (credits != '0); // Stall here without a credit

    always_comb begin
        next_byte = '0;
        next_a0   = 1'b0;
        case (state)
            S_PAGE: begin
                next_byte.cmd.opcode = op_page;
                next_byte.cmd.arg    = page;
            end
            S_COL_HIGH: begin
                next_byte.cmd.opcode = op_col_high;
                next_byte.cmd.arg    = column[7:4];
            end
            S_COL_LOW: begin
                next_byte.cmd.opcode = op_col_low;
                next_byte.cmd.arg    = column[3:0];
            end
            S_DATA: begin
                next_a0 = 1'b1;
                case (data_idx)
                    2'd0:    next_byte.data = char0;
                    2'd1:    next_byte.data = char1;
                    default: next_byte.data = char2;
                endcase
            end
            default: next_byte = '0;
        endcase
    end

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            state    <= S_IDLE;
            push     <= 1'b0;
            credits  <= CNT_W'(CREDITS);
            data_idx <= '0;
        end else begin
            push    <= spend;
            credits <= credits - CNT_W'(spend) + CNT_W'(credit_return);
            case (state)
                S_IDLE: begin
                    data_idx <= '0;
                    if (field_valid) state <= S_PAGE;
                end
                S_PAGE:     if (spend) state <= S_COL_HIGH;
                S_COL_HIGH: if (spend) state <= S_COL_LOW;
                S_COL_LOW:  if (spend) state <= S_DATA;
                S_DATA: begin
                    if (spend) begin
                        data_idx <= data_idx + 2'd1;
                        if (data_idx == length - 2'd1) state <= S_IDLE; // Last character
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK_I) begin
        if (spend) begin
            entry.a0    <= next_a0;
            entry.value <= next_byte;
        end
    end

endmodule

// ==== design/field_mask.sv ====
`timescale 1ns/1ps

module field_mask (
    input  logic             CLK_I,
    input  logic             RST_I,
    input  logic             field_valid,
    input  dash_pkg::field_t field_id,
    input  logic             kmh,
    input  logic             avs,
    input  logic             day,
    input  logic             max,
    input  logic             tim,
    input  logic             point,
    input  logic             colon,
    input  dash_pkg::char_t  lower1,
    input  dash_pkg::char_t  lower10,
    input  dash_pkg::char_t  lower100,
    input  dash_pkg::char_t  lower1000,
    input  dash_pkg::char_t  upper1,
    input  dash_pkg::char_t  upper10,
    output lcd_pkg::page_t   page,
    output lcd_pkg::column_t column,
    output logic [1:0]       length,
    output dash_pkg::char_t  char0,
    output dash_pkg::char_t  char1,
    output dash_pkg::char_t  char2
);
    import dash_pkg::*;

    logic [NUM_FLAGS-1:0]   flags;
    char_t [NUM_DIGITS-1:0] digits;
    logic [2:0]             flag_idx;
    logic [2:0]             digit_idx;

    assign flags     = {colon, point, tim, max, day, avs, kmh};
    assign digits    = {upper10, upper1, lower1000, lower100, lower10, lower1};
    assign flag_idx  = field_id[2:0];
    assign digit_idx = 3'(field_id - fld_lower1);

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            length <= '0;
        end else if (field_valid) begin
            length <= field_length[field_id];
        end
    end

    always_ff @(posedge CLK_I) begin
        if (field_valid) begin
            page   <= field_page[field_id];
            column <= field_column[field_id];
            if (field_id < fld_lower1) begin
                {char0, char1, char2} <= flags[flag_idx] ? flag_text[flag_idx] : 24'h0; // Blank
            end else begin
                char0 <= digits[digit_idx]; // Digit code as given
                char1 <= '0;
                char2 <= '0;
            end
        end
    end

endmodule

// ==== design/change_scanner.sv ====
`timescale 1ns/1ps

module change_scanner (
    input  logic             CLK_I,
    input  logic             RST_I,
    input  logic             kmh,
    input  logic             avs,
    input  logic             day,
    input  logic             max,
    input  logic             tim,
    input  logic             point,
    input  logic             colon,
    input  dash_pkg::char_t  lower1,
    input  dash_pkg::char_t  lower10,
    input  dash_pkg::char_t  lower100,
    input  dash_pkg::char_t  lower1000,
    input  dash_pkg::char_t  upper1,
    input  dash_pkg::char_t  upper10,
    input  logic             idle,
    output logic             field_valid,
    output dash_pkg::field_t field_id
);
    import dash_pkg::*;

    logic [NUM_FLAGS-1:0]   flags;
    logic [NUM_FLAGS-1:0]   flag_shadow;
    char_t [NUM_DIGITS-1:0] digits;
    char_t [NUM_DIGITS-1:0] digit_shadow;
    field_t                 next_id;
    logic                   fire;

    assign flags  = {colon, point, tim, max, day, avs, kmh};
    assign digits = {upper10, upper1, lower1000, lower100, lower10, lower1};

    // Scan from lowest priority up so the highest difference wins
    always_comb begin
        next_id = fld_none;
        for (int i = NUM_DIGITS - 1; i >= 0; i--) begin
            if (digits[i] != digit_shadow[i]) begin
                next_id = field_t'(4'(i + NUM_FLAGS));
            end
        end
        for (int i = NUM_FLAGS - 1; i >= 0; i--) begin
            if (flags[i] != flag_shadow[i]) begin
                next_id = field_t'(4'(i));
            end
        end
    end

    assign fire = idle && !field_valid && (next_id != fld_none); // Sequencer still idle

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            flag_shadow  <= '0;
            digit_shadow <= '0;
            field_valid  <= 1'b0;
            field_id     <= fld_none;
        end else begin
            field_valid <= fire;
            if (fire) begin
                field_id <= next_id;
                for (int i = 0; i < NUM_FLAGS; i++) begin
                    if (next_id == field_t'(4'(i))) begin
                        flag_shadow[i] <= flags[i];
                    end
                end
                for (int i = 0; i < NUM_DIGITS; i++) begin
                    if (next_id == field_t'(4'(i + NUM_FLAGS))) begin
                        digit_shadow[i] <= digits[i];
                    end
                end
            end
        end
    end

endmodule

// ==== design/dash_pkg.sv ====
package dash_pkg;

    typedef logic [7:0] char_t;

    // Declaration order is the scan priority
    typedef enum logic [3:0] {
        fld_kmh, fld_avs, fld_day, fld_max, fld_tim, fld_point, fld_colon,
        fld_lower1, fld_lower10, fld_lower100, fld_lower1000,
        fld_upper1, fld_upper10, fld_none
    } field_t;

    localparam int NUM_FLAGS  = 7;
    localparam int NUM_DIGITS = 6;
    localparam int NUM_FIELDS = NUM_FLAGS + NUM_DIGITS;

    localparam logic [3:0] field_page [NUM_FIELDS] = '{
        4'd2, 4'd3, 4'd2, 4'd5, 4'd4, 4'd5, 4'd5,
        4'd5, 4'd5, 4'd5, 4'd5, 4'd1, 4'd1
    };

    localparam logic [7:0] field_column [NUM_FIELDS] = '{
        8'd105, 8'd15, 8'd15, 8'd15, 8'd15, 8'd96, 8'd79,
        8'd105, 8'd87, 8'd69, 8'd51, 8'd87, 8'd75
    };

    localparam logic [1:0] field_length [NUM_FIELDS] = '{
        2'd3, 2'd3, 2'd3, 2'd3, 2'd3, 2'd1, 2'd1,
        2'd1, 2'd1, 2'd1, 2'd1, 2'd1, 2'd1
    };

    // Text shown while a flag is set, first character in the top byte
    localparam logic [23:0] flag_text [NUM_FLAGS] = '{
        24'h6B6D68, 24'h415653, 24'h444159, 24'h4D4158,
        24'h54494D, 24'h2E0000, 24'h3A0000
    };

endpackage

// ==== design/lcd_pkg.sv ====
package lcd_pkg;

    localparam int BYTE_W = 8;
    localparam int NIBBLE_W = BYTE_W / 2;

    typedef logic [NIBBLE_W-1:0] page_t;
    typedef logic [BYTE_W-1:0]   column_t;

    // Command opcodes, upper nibble of a command byte
    localparam logic [NIBBLE_W-1:0] op_page     = 4'hB;
    localparam logic [NIBBLE_W-1:0] op_col_high = 4'h1;
    localparam logic [NIBBLE_W-1:0] op_col_low  = 4'h0;

    typedef union packed {
        struct packed {
            logic [NIBBLE_W-1:0] opcode;
            logic [NIBBLE_W-1:0] arg;
        } cmd;                            // Command view
        logic [BYTE_W-1:0] data;          // Character code view
    } lcd_byte_t;

    typedef struct packed {
        logic      a0;                    // High for data bytes
        lcd_byte_t value;
    } lcd_entry_t;

endpackage
